// File: reg_bank_system.f
design/inst_pkg.sv
design/bank_pkg.sv
design/reg_bank.sv
design/bank_ctrl_regs.sv
design/reg_bank_top.sv
verification/tb_clock_gen.sv
verification/reg_bank_top_tb.sv

// File: Bender.yml
package:
  name: reg_bank_system

sources:
  # packages first, the RTL depends on them
  - design/inst_pkg.sv
  - design/bank_pkg.sv
  - design/reg_bank.sv
  - design/bank_ctrl_regs.sv
  - design/reg_bank_top.sv
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/reg_bank_top_tb.sv

// File: verification/reg_bank_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank_top_tb
   import inst_pkg::*;
   import bank_pkg::*;
;

   localparam int CYCLE_NS     = 40;
   localparam int RESET_CYCLES = 8;
   localparam int TEST_CYCLES  = 20 + 80 + 90 + 70 + 100;   // per-test budgets
   localparam int MARGIN       = 100;
   localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES + MARGIN) * CYCLE_NS;

   logic       clock;
   logic       reset;
   logic       reset_req;
   inst_word_t inst;
   logic       inst_en;
   cfg_req_t   cfg;
   cfg_addr_t  cfg_rd_addr;
   cfg_data_t  cfg_rdata;
   reg_data_t  out;
   logic       ready;
   logic       error;

   reg_data_t   model [8];   // expected register contents
   logic [15:0] lfsr_state = 16'd36537;
   int          errors = 0;
   int          tests_passed = 0;
   int          tests_failed = 0;

   tb_clock_gen #(
      .HALF_PERIOD_NS (CYCLE_NS / 2),
      .RESET_CYCLES   (RESET_CYCLES)
   ) tb_clock_gen_inst (
      .reset_req (reset_req),
      .clock     (clock),
      .reset     (reset)
   );

   reg_bank_top #(
      .COUNT_WIDTH (8)
   ) reg_bank_top_inst (
      .clock       (clock),
      .reset       (reset),
      .inst        (inst),
      .inst_en     (inst_en),
      .cfg         (cfg),
      .cfg_rd_addr (cfg_rd_addr),
      .cfg_rdata   (cfg_rdata),
      .out         (out),
      .ready       (ready),
      .error       (error)
   );

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic random_bits(input int n, output logic [15:0] value);
      value = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         value = {value[14:0], lfsr_state[0]};
      end
   endtask

   task automatic check_equal(input string what, input logic [15:0] got,
                              input logic [15:0] exp);
      assert (got === exp) else begin
         $display("Fail %0t ns: %s, got %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input string name, input int start_errors);
      if (errors == start_errors) begin
         tests_passed++;
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - start_errors);
      end
   endtask

   task automatic send(input logic [3:0] op, input imm_t imm);
      @(posedge clock);
      inst    <= {op, imm};
      inst_en <= 1'b1;
      @(posedge clock);
      inst_en <= 1'b0;
   endtask

   task automatic write_cfg(input cfg_addr_t addr, input cfg_data_t data);
      @(posedge clock);
      cfg <= '{write: 1'b1, addr: addr, wdata: data};
      @(posedge clock);
      cfg.write <= 1'b0;
   endtask

   task automatic read_cfg(input cfg_addr_t addr, output cfg_data_t data);
      @(posedge clock);
      cfg_rd_addr <= addr;
      @(negedge clock);
      data = cfg_rdata;
   endtask

   // select a register and compare out and the status selection
   task automatic read_back(input int idx);
      cfg_data_t status_word;
      send(RDO, imm_t'(idx));
      read_cfg(CFG_STATUS, status_word);
      check_equal($sformatf("out for reg %0d", idx), out, model[idx]);
      check_equal("status out_select", status_word[4:2], idx[2:0]);
   endtask

   task automatic wait_for_ready(input int limit);
      int cycles;
      cycles = 0;
      @(negedge clock);
      while (!ready && cycles < limit) begin
         @(negedge clock);
         cycles++;
      end
      assert (ready) else begin
         $display("ready did not rise within %0d cycles after reset", limit);
         errors++;
      end
   endtask

   task automatic test_reset_startup();
      int        start;
      cfg_data_t data;
      start = errors;
      @(negedge clock);
      check_equal("ready during reset", ready, 1'b0);
      check_equal("error during reset", error, 1'b0);
      check_equal("out during reset", out, 8'h00);
      while (reset) begin
         @(negedge clock);
      end
      check_equal("ready in INIT cycle", ready, 1'b0);
      @(negedge clock);
      check_equal("ready one cycle after reset", ready, 1'b1);
      read_cfg(CFG_LOCK, data);
      check_equal("lock mask after reset", data, 16'h0000);
      read_cfg(CFG_EXEC, data);
      check_equal("executed count after reset", data, 16'h0000);
      read_cfg(CFG_BLOCKED, data);
      check_equal("blocked count after reset", data, 16'h0000);
      read_cfg(CFG_STATUS, data);
      check_equal("status after reset", data, 16'h0001);
      finish_test("reset and start-up", start);
   endtask

   task automatic test_load_readback();
      int          start;
      int          order [8];
      int          j;
      int          tmp;
      logic [15:0] r;
      cfg_data_t   data;
      start = errors;
      write_cfg(CFG_EXEC, '0);
      for (int i = 0; i < 8; i++) begin
         random_bits(8, r);
         model[i] = r[7:0];
         send(4'(LD0 + i), r[7:0]);
         order[i] = i;
      end
      for (int i = 7; i > 0; i--) begin   // Fisher-Yates
         random_bits(3, r);
         j = r % (i + 1);
         tmp = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      for (int i = 0; i < 8; i++) begin
         read_back(order[i]);
      end
      read_cfg(CFG_EXEC, data);
      check_equal("executed count", data, 16'd16);
      finish_test("load and read-back", start);
   endtask

   task automatic test_write_lock();
      int          start;
      int          locked;
      logic [15:0] r;
      logic [7:0]  mask;
      cfg_data_t   data;
      start = errors;
      locked = 0;
      random_bits(8, r);
      mask = r[7:0];
      write_cfg(CFG_BLOCKED, '0);
      write_cfg(CFG_LOCK, {8'h00, mask});
      read_cfg(CFG_LOCK, data);
      check_equal("lock mask read-back", data, {8'h00, mask});
      for (int i = 0; i < 8; i++) begin
         random_bits(8, r);
         send(4'(LD0 + i), r[7:0]);
         if (mask[i]) begin
            locked++;
         end else begin
            model[i] = r[7:0];
         end
      end
      for (int i = 0; i < 8; i++) begin
         read_back(i);
      end
      read_cfg(CFG_BLOCKED, data);
      check_equal("blocked count", data, 16'(locked));
      write_cfg(CFG_BLOCKED, 16'hFFFF);   // any write clears
      read_cfg(CFG_BLOCKED, data);
      check_equal("blocked count after clear", data, 16'h0000);
      write_cfg(CFG_LOCK, '0);
      finish_test("write lock", start);
   endtask

   task automatic test_nop_idle();
      int          start;
      logic [15:0] r;
      reg_data_t   held;
      cfg_data_t   data;
      start = errors;
      send(RDO, 8'h00);   // idle loads below target reg 0
      write_cfg(CFG_EXEC, '0);
      @(negedge clock);
      held = out;
      for (int i = 0; i < 3; i++) begin
         random_bits(8, r);
         send(NOP, r[7:0]);
         @(negedge clock);
         check_equal("out after NOP", out, held);
      end
      for (int i = 0; i < 5; i++) begin
         random_bits(8, r);
         @(posedge clock);
         inst <= {LD0, r[7:0]};   // strobe stays low
         @(negedge clock);
         check_equal("out in idle cycle", out, held);
      end
      read_cfg(CFG_EXEC, data);
      check_equal("executed count after NOPs", data, 16'd3);
      for (int i = 0; i < 8; i++) begin
         read_back(i);
      end
      finish_test("NOP and idle cycles", start);
   endtask

   task automatic test_illegal_opcode();
      int          start;
      logic [15:0] r;
      cfg_data_t   exec_before;
      cfg_data_t   blocked_before;
      cfg_data_t   data;
      start = errors;
      read_cfg(CFG_EXEC, exec_before);
      read_cfg(CFG_BLOCKED, blocked_before);
      random_bits(3, r);
      send(4'(10 + (r % 6)), 8'h5A);
      @(negedge clock);
      check_equal("error after illegal opcode", error, 1'b1);
      check_equal("ready after illegal opcode", ready, 1'b0);
      check_equal("out after illegal opcode", out, 8'h00);
      for (int i = 0; i < 3; i++) begin
         random_bits(8, r);
         send(4'(LD0 + i), r[7:0]);
         send(RDO, imm_t'(i));
         @(negedge clock);
         check_equal("out while in ERROR", out, 8'h00);
         check_equal("error stays high", error, 1'b1);
      end
      read_cfg(CFG_EXEC, data);
      check_equal("executed count in ERROR", data, exec_before);
      read_cfg(CFG_BLOCKED, data);
      check_equal("blocked count in ERROR", data, blocked_before);
      @(posedge clock);
      reset_req <= 1'b1;
      @(posedge clock);
      reset_req <= 1'b0;
      wait_for_ready(RESET_CYCLES + 10);
      check_equal("error after new reset", error, 1'b0);
      for (int i = 0; i < 8; i++) begin
         model[i] = '0;
      end
      read_cfg(CFG_EXEC, data);
      check_equal("executed count after new reset", data, 16'h0000);
      for (int i = 0; i < 8; i++) begin
         read_back(i);
      end
      finish_test("illegal opcode", start);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      reset_req   = 1'b0;
      inst        = '0;
      inst_en     = 1'b0;
      cfg         = '0;
      cfg_rd_addr = '0;
      for (int i = 0; i < 8; i++) begin
         model[i] = '0;
      end
      test_reset_startup();
      test_load_readback();
      test_write_lock();
      test_nop_idle();
      test_illegal_opcode();
      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int HALF_PERIOD_NS = 20,
   parameter int RESET_CYCLES   = 8
)
(
   input  wire logic reset_req,   // restarts the reset sequence
   output logic      clock,
   output logic      reset
);

   int count;

   initial begin
      clock = 1'b0;
      forever #(HALF_PERIOD_NS) clock = ~clock;
   end

   initial begin
      reset = 1'b1;
      count = 0;
   end

   always @(posedge clock) begin
      if (reset_req) begin
         reset <= 1'b1;
         count <= 0;
      end else if (reset) begin
         if (count == RESET_CYCLES - 1) begin
            reset <= 1'b0;
         end
         count <= count + 1;
      end
   end

endmodule

`default_nettype wire

// File: design/reg_bank_top.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank_top
   import inst_pkg::*;
   import bank_pkg::*;
#(
   parameter int COUNT_WIDTH = 16
)
(
   input  wire logic       clock,
   input  wire logic       reset,
   input  wire inst_word_t inst,
   input  wire logic       inst_en,
   input  wire cfg_req_t   cfg,
   input  wire cfg_addr_t  cfg_rd_addr,
   output wire cfg_data_t  cfg_rdata,
   output wire reg_data_t  out,
   output wire logic       ready,
   output wire logic       error
);

   wire bank_status_t status;
   wire bank_event_t  evt;
   wire lock_mask_t   lock_mask;

   reg_bank reg_bank_inst (
      .clock     (clock),
      .reset     (reset),
      .inst      (inst),
      .inst_en   (inst_en),
      .lock_mask (lock_mask),
      .out       (out),
      .status    (status),
      .evt       (evt)
   );

   bank_ctrl_regs #(
      .COUNT_WIDTH (COUNT_WIDTH)
   ) bank_ctrl_regs_inst (
      .clock       (clock),
      .reset       (reset),
      .cfg         (cfg),
      .cfg_rd_addr (cfg_rd_addr),
      .status      (status),
      .evt         (evt),
      .lock_mask   (lock_mask),
      .cfg_rdata   (cfg_rdata)
   );

   assign ready = status.ready;
   assign error = status.error;

endmodule

`default_nettype wire

// File: design/bank_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bank_ctrl_regs
   import bank_pkg::*;
#(
   parameter int COUNT_WIDTH = 16
)
(
   input  wire logic         clock,
   input  wire logic         reset,
   input  wire cfg_req_t     cfg,
   input  wire cfg_addr_t    cfg_rd_addr,
   input  wire bank_status_t status,
   input  wire bank_event_t  evt,
   output lock_mask_t        lock_mask,
   output cfg_data_t         cfg_rdata
);

   typedef logic [COUNT_WIDTH-1:0] count_t;

   count_t exec_count;
   count_t blocked_count;

   logic wr_lock;
   logic clr_exec;
   logic clr_blocked;

   // clear beats a same-cycle increment and counters wrap
   function automatic count_t count_next(count_t count, logic clear, logic incr);
      if (clear) begin
         return '0;
      end
      return incr ? count + 1'b1 : count;
   endfunction

   assign wr_lock     = cfg.write && (cfg.addr == CFG_LOCK);
   assign clr_exec    = cfg.write && (cfg.addr == CFG_EXEC);
   assign clr_blocked = cfg.write && (cfg.addr == CFG_BLOCKED);

   always_ff @(posedge clock) begin
      if (reset) begin
         lock_mask <= '0;
      end else if (wr_lock) begin
         lock_mask <= cfg.wdata[$bits(lock_mask_t)-1:0];
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         exec_count    <= '0;
         blocked_count <= '0;
      end else begin
         exec_count    <= count_next(exec_count, clr_exec, evt.accepted);
         blocked_count <= count_next(blocked_count, clr_blocked, evt.blocked);
      end
   end

   always_comb begin
      cfg_rdata = '0;
      case (cfg_rd_addr)
         CFG_LOCK: begin
            cfg_rdata[$bits(lock_mask_t)-1:0] = lock_mask;
         end
         CFG_EXEC: begin
            cfg_rdata = cfg_data_t'(exec_count);   // zero-extended
         end
         CFG_BLOCKED: begin
            cfg_rdata = cfg_data_t'(blocked_count);
         end
         CFG_STATUS: begin
            cfg_rdata[0]   = status.ready;
            cfg_rdata[1]   = status.error;
            cfg_rdata[4:2] = status.out_select;
         end
         default: begin
            cfg_rdata = '0;
         end
      endcase
   end

   a_count_width: assert property (
      @(posedge clock) COUNT_WIDTH inside {[4:16]}
   );

endmodule

`default_nettype wire

// File: design/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank
   import inst_pkg::*;
   import bank_pkg::*;
(
   input  wire logic       clock,
   input  wire logic       reset,
   input  wire inst_word_t inst,
   input  wire logic       inst_en,
   input  wire lock_mask_t lock_mask,
   output reg_data_t       out,
   output bank_status_t    status,
   output bank_event_t     evt
);

   bank_state_t state;
   reg_data_t   regs [NUM_REGS];
   reg_index_t  out_select;

   logic       take;
   logic       legal;
   logic       load;
   reg_index_t ld_idx;
   logic       ld_locked;
   logic       clear_all;

   // instructions only count in READY
   assign take      = inst_en && (state == READY);
   assign legal     = is_legal(inst.opcode);
   assign load      = is_load(inst.opcode);
   assign ld_idx    = load_index(inst.opcode);
   assign ld_locked = lock_mask[ld_idx];
   assign clear_all = take && !legal;

   always_ff @(posedge clock) begin
      if (reset) begin
         state <= INIT;
      end else begin
         case (state)
            INIT: begin
               state <= READY;
            end
            READY: begin
               if (clear_all) begin
                  state <= ERROR;
               end
            end
            ERROR: begin
               state <= ERROR;   // only reset leaves
            end
            default: begin
               state <= ERROR;
            end
         endcase
      end
   end

   // register file and output selection
   always_ff @(posedge clock) begin
      if (reset || clear_all) begin
         regs       <= '{default: '0};
         out_select <= '0;
      end else if (take) begin
         if (inst.opcode == RDO) begin
            out_select <= inst.imm[2:0];
         end
         if (load && !ld_locked) begin
            regs[ld_idx] <= inst.imm;
         end
      end
   end

   // one-cycle pulses for the counters
   always_ff @(posedge clock) begin
      if (reset) begin
         evt <= '0;
      end else begin
         evt.accepted <= take && legal;
         evt.blocked  <= take && load && ld_locked;
      end
   end

   assign out = regs[out_select];

   always_comb begin
      status.ready      = (state == READY);
      status.error      = (state == ERROR);
      status.out_select = out_select;
   end

   // regs are wiped on the way into ERROR
   a_error_out_zero: assert property (
      @(posedge clock) disable iff (reset)
      state == ERROR |-> out == '0
   );

   a_blocked_accepted: assert property (
      @(posedge clock) disable iff (reset)
      evt.blocked |-> evt.accepted
   );

   a_state_known: assert property (
      @(posedge clock) disable iff (reset)
      state inside {INIT, READY, ERROR}
   );

endmodule

`default_nettype wire

// File: design/bank_pkg.sv
`default_nettype none

package bank_pkg;

   localparam int NUM_REGS = 8;

   typedef enum logic [1:0] {
      INIT  = 2'd0,
      READY = 2'd1,
      ERROR = 2'd2   // sticky until reset
   } bank_state_t;

   typedef logic [7:0]          reg_data_t;
   typedef logic [2:0]          reg_index_t;
   typedef logic [NUM_REGS-1:0] lock_mask_t;   // set bit locks that register

   typedef struct packed {
      logic       ready;
      logic       error;
      reg_index_t out_select;
   } bank_status_t;

   typedef struct packed {
      logic accepted;   // legal instruction executed
      logic blocked;    // load refused by lock
   } bank_event_t;

   typedef logic [1:0]  cfg_addr_t;
   typedef logic [15:0] cfg_data_t;

   // config register map
   localparam cfg_addr_t CFG_LOCK    = 2'd0;
   localparam cfg_addr_t CFG_EXEC    = 2'd1;
   localparam cfg_addr_t CFG_BLOCKED = 2'd2;
   localparam cfg_addr_t CFG_STATUS  = 2'd3;

   typedef struct packed {
      logic      write;
      cfg_addr_t addr;
      cfg_data_t wdata;
   } cfg_req_t;

endpackage

`default_nettype wire

// File: design/inst_pkg.sv
`default_nettype none

package inst_pkg;

   // 4-bit instruction codes, 10 to 15 are illegal
   typedef enum logic [3:0] {
      NOP = 4'h0,
      RDO = 4'h1,   // select output register
      LD0 = 4'h2,
      LD1 = 4'h3,
      LD2 = 4'h4,
      LD3 = 4'h5,
      LD4 = 4'h6,
      LD5 = 4'h7,
      LD6 = 4'h8,
      LD7 = 4'h9
   } opcode_t;

   typedef logic [7:0] imm_t;

   typedef struct packed {
      opcode_t opcode;   // bits 11:8
      imm_t    imm;      // bits 7:0, low 3 bits select for RDO
   } inst_word_t;

   function automatic logic is_legal(opcode_t op);
      return op <= LD7;
   endfunction

   function automatic logic is_load(opcode_t op);
      return op inside {[LD0:LD7]};
   endfunction

   // register number targeted by LDn
   function automatic logic [2:0] load_index(opcode_t op);
      return 3'(op - LD0);
   endfunction

endpackage

`default_nettype wire
